//--- include/width_consts.svh
// width converter constants
// sample width, packing factors and the widths derived from them
`ifndef WIDTH_CONSTS_SVH
`define WIDTH_CONSTS_SVH

// width of one narrow input sample in bits
`define WIDTH_IN_BITS 12

// number of input samples the upsizer packs into one wide word
`define WIDTH_UP_FACTOR 4

// number of output pieces the downsizer cuts one wide word into
`define WIDTH_DOWN_FACTOR 3

// width of the wide word between the upsizer and the downsizer
// every lane of the upsizer is placed side by side in it
`define WIDTH_WIDE_BITS (`WIDTH_IN_BITS * `WIDTH_UP_FACTOR)

// width of one output piece
// the wide word must divide evenly by the down factor for this to hold
`define WIDTH_OUT_BITS (`WIDTH_WIDE_BITS / `WIDTH_DOWN_FACTOR)

// with the values above the converter turns 4 samples of 12 bits
// into 3 pieces of 16 bits, a net rate change of 4:3
// a frame that ends on a partial word gives fewer real pieces,
// which the downsizer works out from the fill count
// changing the factors keeps the RTL valid as long as the
// wide width stays an integer multiple of the down factor

`endif

//--- logic/width_conv_pkg.sv
// width converter types
// two views of the wide word and the lane fill count passed with it

`include "width_consts.svh"

package width_conv_pkg;

  // number of filled input lanes in a wide word
  // runs from 1 up to the upsizer factor, so it needs one bit more
  // than a plain lane index would
  typedef logic [$clog2(`WIDTH_UP_FACTOR + 1)-1:0] fill_count_t;

  // one wide word seen in two ways
  // the upsizer writes it lane by lane as narrow samples arrive
  // the downsizer reads it piece by piece on the output side
  // lane 0 and piece 0 share the least significant bits, so the
  // first sample of a group leaves first on the output
  typedef union packed {
    // input side view, one entry per narrow sample
    logic [`WIDTH_UP_FACTOR-1:0][`WIDTH_IN_BITS-1:0] lanes;
    // output side view, one entry per output piece
    logic [`WIDTH_DOWN_FACTOR-1:0][`WIDTH_OUT_BITS-1:0] pieces;
  } wide_word_u;

  // with 12 bit lanes and 16 bit pieces the views do not line up
  // lane 1 for example straddles pieces 0 and 1
  // piece 0 holds lane 0 and the low nibble of lane 1
  // piece 1 holds the rest of lane 1 and the low byte of lane 2
  // piece 2 holds the top of lane 2 and all of lane 3
  // a partial word therefore can end in the middle of a piece,
  // and the bits above the last filled lane are stale
  // the downsizer rounds the piece count up so such a piece is sent
  // and the receiver ignores its unfilled upper bits

endpackage

//--- logic/stream_upsizer.sv
// stream upsizer
// packs consecutive narrow samples into one wide word with a lane fill count
`timescale 1ns/1ps

`include "width_consts.svh"

module stream_upsizer (
  input  logic                        clk,
  input  logic                        reset,
  // narrow sample stream
  input  logic                        s_valid,
  input  logic [`WIDTH_IN_BITS-1:0]   s_data,
  input  logic                        s_last,
  output logic                        s_ready,
  // wide word stream towards the downsizer
  output logic                        w_valid,
  output width_conv_pkg::wide_word_u  w_word,
  output width_conv_pkg::fill_count_t w_fill,
  output logic                        w_last,
  input  logic                        w_ready
);

  import width_conv_pkg::*;

  // lane index needs at least one bit even for a factor of one
  localparam int LANE_BITS = (`WIDTH_UP_FACTOR > 1) ? $clog2(`WIDTH_UP_FACTOR) : 1;

  // lane that the next accepted sample goes into
  logic [LANE_BITS-1:0] lane_cnt;
  // the word under assembly, which doubles as the output word
  wide_word_u           word_q;
  fill_count_t          fill_q;
  logic                 valid_q;
  logic                 last_q;

  logic                 s_xfer;
  logic                 at_last_lane;
  logic                 write_final;

  // input only moves while the downsizer can take a word, so a full
  // output register never gets overwritten
  assign s_ready = w_ready;

  assign s_xfer       = s_valid && s_ready;
  assign at_last_lane = (lane_cnt == LANE_BITS'(`WIDTH_UP_FACTOR - 1));

  // a word is complete on its final lane or when the frame ends early
  // in the second case the lanes above keep whatever they held before
  assign write_final = s_xfer && (at_last_lane || s_last);

  assign w_valid = valid_q;
  assign w_word  = word_q;
  assign w_fill  = fill_q;
  assign w_last  = last_q;

  // lane counter and output flags
  always_ff @(posedge clk) begin
    if (reset) begin
      lane_cnt <= '0;
      valid_q  <= 1'b0;
      last_q   <= 1'b0;
    end else begin
      if (s_xfer) begin
        if (write_final) begin
          // restart at lane 0 for the next group or frame
          lane_cnt <= '0;
        end else begin
          lane_cnt <= lane_cnt + 1'b1;
        end
      end
      // the output register may change only when empty or being taken
      if (!valid_q || w_ready) begin
        valid_q <= write_final;
        last_q  <= write_final && s_last;
      end
    end
  end

  // sample lanes and fill count carry no reset
  always_ff @(posedge clk) begin
    if (s_xfer) begin
      // writing lane 0 while the old word leaves is safe, since the
      // downsizer registers the old word on this same edge
      word_q.lanes[lane_cnt] <= s_data;
    end
    if (write_final) begin
      // the completing sample itself fills lane_cnt, hence the plus one
      fill_q <= fill_count_t'(lane_cnt) + fill_count_t'(1);
    end
  end

  // the path from w_ready to s_ready is purely combinational
  // which lets the upsizer run at full rate when the output keeps up
  // a stall on the output side therefore reaches the input in the
  // same cycle, and assembly pauses with the lane counter held

endmodule

//--- logic/stream_downsizer.sv
// stream downsizer
// splits each wide word into output pieces, skipping pieces with no real data
`timescale 1ns/1ps

`include "width_consts.svh"

module stream_downsizer (
  input  logic                        clk,
  input  logic                        reset,
  // wide word stream from the upsizer
  input  logic                        w_valid,
  input  width_conv_pkg::wide_word_u  w_word,
  input  width_conv_pkg::fill_count_t w_fill,
  input  logic                        w_last,
  output logic                        w_ready,
  // output piece stream
  output logic                        m_valid,
  output logic [`WIDTH_OUT_BITS-1:0]  m_data,
  output logic                        m_last,
  input  logic                        m_ready
);

  import width_conv_pkg::*;

  // piece index needs at least one bit even for a factor of one
  localparam int PIECE_BITS = (`WIDTH_DOWN_FACTOR > 1) ? $clog2(`WIDTH_DOWN_FACTOR) : 1;

  // index of the last piece that holds any filled lane bits
  // the piece count is the filled bit count over the piece width,
  // rounded up, so a piece that is only partly filled is still sent
  function automatic logic [PIECE_BITS-1:0] final_piece(fill_count_t fill);
    int filled_bits;
    int pieces;
    filled_bits = int'(fill) * `WIDTH_IN_BITS;
    pieces      = (filled_bits + `WIDTH_OUT_BITS - 1) / `WIDTH_OUT_BITS;
    return PIECE_BITS'(pieces - 1);
  endfunction

  // registered word and its split state
  wide_word_u            word_q;
  logic [PIECE_BITS-1:0] final_q;
  logic [PIECE_BITS-1:0] piece_cnt;
  logic                  valid_q;
  logic                  last_q;

  logic                  w_xfer;
  logic                  m_xfer;
  logic                  at_final;

  assign at_final = (piece_cnt == final_q);
  assign m_xfer   = valid_q && m_ready;
  assign w_xfer   = w_valid && w_ready;

  // take a new word when empty, or when the current word sends its
  // final real piece on this edge, so words follow back to back
  assign w_ready = !valid_q || (m_ready && at_final);

  assign m_valid = valid_q;
  assign m_data  = word_q.pieces[piece_cnt];
  // a frame ends on the last real piece, never on an empty one
  assign m_last  = last_q && at_final;

  // control state
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q   <= 1'b0;
      last_q    <= 1'b0;
      piece_cnt <= '0;
    end else begin
      if (w_ready) begin
        // either loads a new word or goes empty after the final piece
        valid_q <= w_valid;
        last_q  <= w_valid && w_last;
      end
      if (m_xfer) begin
        if (at_final) begin
          // empty pieces above the final one are never visited
          piece_cnt <= '0;
        end else begin
          piece_cnt <= piece_cnt + 1'b1;
        end
      end
    end
  end

  // word payload and its final piece index, loaded on each word transfer
  always_ff @(posedge clk) begin
    if (w_xfer) begin
      word_q  <= w_word;
      final_q <= final_piece(w_fill);
    end
  end

  // with the default widths the fill count maps to pieces as
  // 4 lanes to 3 pieces, 3 lanes to 3, 2 lanes to 2 and 1 lane to 1
  // while m_ready is low the counter and the word hold, so m_data and
  // m_last stay stable, and w_ready stays low to stall the upsizer
  // piece_cnt is always zero when a new word loads, because a load
  // only happens when empty or on the final piece transfer, and both
  // of those leave the counter at zero

endmodule

//--- logic/stream_width_converter.sv
// stream width converter
// an upsizer followed by a downsizer, turning 12 bit samples into 16 bit pieces
`timescale 1ns/1ps

`include "width_consts.svh"

module stream_width_converter (
  input  logic                       clk,
  input  logic                       reset,
  // narrow sample input
  input  logic                       s_valid,
  input  logic [`WIDTH_IN_BITS-1:0]  s_data,
  input  logic                       s_last,
  output logic                       s_ready,
  // output pieces
  output logic                       m_valid,
  output logic [`WIDTH_OUT_BITS-1:0] m_data,
  output logic                       m_last,
  input  logic                       m_ready
);

  import width_conv_pkg::*;

  // wide word path between the two stages
  logic        w_valid;
  logic        w_ready;
  wide_word_u  w_word;
  fill_count_t w_fill;
  logic        w_last;

  // packs samples into wide words, one cycle after the completing sample
  stream_upsizer upsizer_i (
    .clk     (clk),
    .reset   (reset),
    .s_valid (s_valid),
    .s_data  (s_data),
    .s_last  (s_last),
    .s_ready (s_ready),
    .w_valid (w_valid),
    .w_word  (w_word),
    .w_fill  (w_fill),
    .w_last  (w_last),
    .w_ready (w_ready)
  );

  // splits wide words into pieces and drops the empty ones
  // its w_ready decides whether the upsizer, and so the input, may move
  stream_downsizer downsizer_i (
    .clk     (clk),
    .reset   (reset),
    .w_valid (w_valid),
    .w_word  (w_word),
    .w_fill  (w_fill),
    .w_last  (w_last),
    .w_ready (w_ready),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_last  (m_last),
    .m_ready (m_ready)
  );

endmodule

//--- bench/stream_width_converter_tb.sv
// testbench for the stream width converter
// random frames under back-pressure, checked against pieces packed from the input samples
`timescale 1ns/1ps

`include "width_consts.svh"

module stream_width_converter_tb;

  localparam int IN_BITS    = `WIDTH_IN_BITS;
  localparam int UP_FACTOR  = `WIDTH_UP_FACTOR;
  localparam int OUT_BITS   = `WIDTH_OUT_BITS;
  localparam int WIDE_BITS  = `WIDTH_WIDE_BITS;
  localparam int NUM_FRAMES = 60;
  localparam int MAX_LEN    = 9;
  // every sample of the longest frames at about four cycles each,
  // plus margin for reset, idle cycles and the final drain
  localparam int MAX_CYCLES = NUM_FRAMES * MAX_LEN * 4 + 840;

  logic                clk;
  logic                reset;
  logic                s_valid;
  logic [IN_BITS-1:0]  s_data;
  logic                s_last;
  logic                s_ready;
  logic                m_valid;
  logic [OUT_BITS-1:0] m_data;
  logic                m_last;
  logic                m_ready;

  integer seed;
  int     cycles          = 0;
  int     frames_received = 0;
  int     data_errors     = 0;
  int     last_errors     = 0;
  int     stall_errors    = 0;
  int     reset_errors    = 0;
  int     other_errors    = 0;

  // expected output pieces in order, with the bits that carry real data
  logic [OUT_BITS-1:0] exp_data_q [$];
  logic [OUT_BITS-1:0] exp_mask_q [$];
  logic                exp_last_q [$];

  // samples of the frame being sent
  logic [IN_BITS-1:0]  frame_samples [MAX_LEN];

  stream_width_converter dut_i (
    .clk     (clk),
    .reset   (reset),
    .s_valid (s_valid),
    .s_data  (s_data),
    .s_last  (s_last),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_last  (m_last),
    .m_ready (m_ready)
  );

  // 40 ns clock period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic int error_total();
    return data_errors + last_errors + stall_errors + reset_errors + other_errors;
  endfunction

  task automatic print_counts();
    $display("errors: data %0d, last %0d, stall %0d, reset %0d, other %0d",
             data_errors, last_errors, stall_errors, reset_errors, other_errors);
  endtask

  // wait for the next rising edge, note whether a sample was taken on it,
  // then move m_ready 5 ns later, low about 30% of the time
  task automatic step_cycle(output logic took);
    @(posedge clk);
    took = s_valid && s_ready;
    #5;
    m_ready = ({$random(seed)} % 10) >= 3;
  endtask

  // packs the frame in groups of four lanes, lane 0 in the low bits,
  // and keeps the pieces that hold at least one filled bit
  task automatic queue_expected(input int len);
    logic [WIDE_BITS-1:0] word;
    int base;
    int fill;
    int k;
    int p;
    int num_pieces;
    int filled;
    for (base = 0; base < len; base += UP_FACTOR) begin
      fill = ((len - base) < UP_FACTOR) ? (len - base) : UP_FACTOR;
      word = '0;
      for (k = 0; k < fill; k++) begin
        word[k*IN_BITS +: IN_BITS] = frame_samples[base + k];
      end
      num_pieces = (fill * IN_BITS + OUT_BITS - 1) / OUT_BITS;
      for (p = 0; p < num_pieces; p++) begin
        // only the final piece of a partial group can be partly filled
        filled = fill * IN_BITS - p * OUT_BITS;
        if (filled > OUT_BITS) begin
          filled = OUT_BITS;
        end
        exp_data_q.push_back(word[p*OUT_BITS +: OUT_BITS]);
        exp_mask_q.push_back(OUT_BITS'((1 << filled) - 1));
        exp_last_q.push_back((base + fill == len) && (p == num_pieces - 1));
      end
    end
  endtask

  // sends one frame with random idle gaps between its samples
  task automatic send_frame(input int len);
    logic took;
    int   gap;
    int   i;
    for (i = 0; i < len; i++) begin
      frame_samples[i] = IN_BITS'($random(seed));
    end
    queue_expected(len);
    for (i = 0; i < len; i++) begin
      // half of the samples follow straight on, the rest wait 1 or 2 cycles
      gap = 0;
      if (({$random(seed)} % 2) == 1) begin
        gap = 1 + {$random(seed)} % 2;
      end
      s_valid = 1'b0;
      repeat (gap) step_cycle(took);
      s_valid = 1'b1;
      s_data  = frame_samples[i];
      s_last  = (i == len - 1);
      took    = 1'b0;
      // hold the sample until the DUT takes it
      while (!took) begin
        step_cycle(took);
      end
    end
    s_valid = 1'b0;
    s_last  = 1'b0;
  endtask

  initial begin : stimulus
    logic took;
    int   frame;
    int   len;
    seed    = 46;
    reset   = 1'b1;
    s_valid = 1'b0;
    s_data  = '0;
    s_last  = 1'b0;
    m_ready = 1'b0;
    // reset stays high over 8 rising edges
    repeat (8) step_cycle(took);
    reset = 1'b0;
    // idle cycles so the state right after reset can be seen
    repeat (2) step_cycle(took);
    for (frame = 0; frame < NUM_FRAMES; frame++) begin
      len = 1 + {$random(seed)} % MAX_LEN;
      send_frame(len);
    end
    // keep back-pressure going while the last frames drain
    while (frames_received < NUM_FRAMES) begin
      step_cycle(took);
    end
    repeat (10) step_cycle(took);
    assert (exp_data_q.size() == 0) else begin
      other_errors++;
      $display("%0d expected output pieces were never received", exp_data_q.size());
    end
    print_counts();
    if (error_total() == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // compares every output transfer with the front of the expected queue
  always @(posedge clk) begin : scoreboard
    logic [OUT_BITS-1:0] exp_data;
    logic [OUT_BITS-1:0] exp_mask;
    logic                exp_last;
    if (!reset && m_valid && m_ready) begin
      if (exp_data_q.size() == 0) begin
        other_errors++;
        $display("output piece at time %0t arrived when none was expected", $time);
      end else begin
        exp_data = exp_data_q.pop_front();
        exp_mask = exp_mask_q.pop_front();
        exp_last = exp_last_q.pop_front();
        // bits above the filled lanes hold stale data and are not compared
        assert ((m_data & exp_mask) === (exp_data & exp_mask)) else begin
          data_errors++;
          $display("FAILED t=%0t m_data expected %h got %h",
                   $time, exp_data & exp_mask, m_data & exp_mask);
        end
        assert (m_last === exp_last) else begin
          last_errors++;
          $display("FAILED t=%0t m_last expected %0b got %0b", $time, exp_last, m_last);
        end
        if (exp_last) begin
          frames_received++;
        end
      end
    end
  end

  // a frame end is only ever flagged on a valid piece
  last_only_with_valid: assert property (@(posedge clk) disable iff (reset)
      m_last |-> m_valid)
    else begin
      last_errors++;
      $display("FAILED t=%0t m_last expected 0 got 1 while m_valid was low", $time);
    end

  // a stalled piece holds until it is taken
  hold_under_backpressure: assert property (@(posedge clk) disable iff (reset)
      (m_valid && !m_ready) |=> (m_valid && $stable(m_data) && $stable(m_last)))
    else begin
      stall_errors++;
      $display("output piece changed or dropped while m_ready was low at time %0t", $time);
    end

  // the DUT comes out of reset empty and ready for input
  idle_after_reset: assert property (@(posedge clk)
      $fell(reset) |-> (!m_valid && !m_last && s_ready))
    else begin
      reset_errors++;
      $display("DUT was not idle on the first edge after reset at time %0t", $time);
    end

  idle_after_reset_next: assert property (@(posedge clk)
      $fell(reset) |=> (!m_valid && !m_last && s_ready))
    else begin
      reset_errors++;
      $display("DUT was not idle on the second edge after reset at time %0t", $time);
    end

  // watchdog on the whole run
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      other_errors++;
      $display("timeout after %0d cycles with %0d of %0d frames received",
               cycles, frames_received, NUM_FRAMES);
      print_counts();
      $display("Something failed");
      $finish;
    end
  end

endmodule

//--- stream_width_converter.f
+incdir+include
logic/width_conv_pkg.sv
logic/stream_upsizer.sv
logic/stream_downsizer.sv
logic/stream_width_converter.sv
bench/stream_width_converter_tb.sv

//--- Bender.yml
package:
  name: stream_width_converter

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/width_conv_pkg.sv
      - logic/stream_upsizer.sv
      - logic/stream_downsizer.sv
      - logic/stream_width_converter.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/stream_width_converter_tb.sv
